// ==== flist.f ====
+incdir+include
src/md_loader_pkg.sv
src/cart_writer.sv
src/region_detect.sv
src/quirk_detect.sv
src/cheat_loader.sv
src/md_loader_top.sv
verif/md_loader_chk.sv
verif/md_loader_tb.sv

// ==== include/md_loader_settings.svh ====
// Cartridge loader settings
`ifndef MD_LOADER_SETTINGS_SVH
`define MD_LOADER_SETTINGS_SVH

// Download bus widths
`define MD_ADDR_W 25
`define MD_DATA_W 16

// All-ones index marks a cheat code download
`define MD_CODE_INDEX 8'hFF

// Cartridge header locations
`define MD_HDR_REGION_A 25'h1F0
`define MD_HDR_REGION_B 25'h1F2
`define MD_HDR_END      25'h200
`define MD_SERIAL_FIRST 25'h182
`define MD_SERIAL_DONE  25'h18C

// Word offsets inside one cheat code slot
`define MD_CHEAT_FLAGS_LO 4'd0
`define MD_CHEAT_FLAGS_HI 4'd2
`define MD_CHEAT_ADDR_LO  4'd4
`define MD_CHEAT_ADDR_HI  4'd6
`define MD_CHEAT_CMP_LO   4'd8
`define MD_CHEAT_CMP_HI   4'd10
`define MD_CHEAT_REPL_LO  4'd12
`define MD_CHEAT_REPL_HI  4'd14

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module md_loader_tb \
	-f flist.f \
	-o Vmd_loader_tb

status=0
./obj_dir/Vmd_loader_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
	exit 0
fi
echo "simulation failed (exit status $status)"
exit 1

// ==== src/cart_writer.sv ====
// Cartridge ROM writer
`timescale 1ns/1ps
`include "md_loader_settings.svh"

module cart_writer (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  cart_load,
	input  logic                  cart_wr,
	input  logic [`MD_ADDR_W-1:0] addr,
	input  logic [`MD_DATA_W-1:0] data,
	input  logic                  mem_wr_ack,
	output logic                  host_wait,
	output logic [`MD_ADDR_W-1:0] mem_addr,
	output logic [`MD_DATA_W-1:0] mem_din,
	output logic                  mem_wr_req,
	output logic [`MD_ADDR_W-1:0] rom_size
);

	logic load_d;

	// Memory expects the high byte first
	assign mem_din = {data[7:0], data[15:8]};

	// Once loading is over the memory port shows the image size
	assign mem_addr = cart_load ? addr : rom_size;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			load_d     <= 1'b0;
			host_wait  <= 1'b0;
			mem_wr_req <= 1'b0;
			rom_size   <= '0;
		end else begin
			load_d <= cart_load;

			// Last address of the download is the image size
			if (load_d && !cart_load) begin
				rom_size  <= addr;
				host_wait <= 1'b0;
			end

			if (!load_d && cart_load) begin
				mem_wr_req <= 1'b0;
			end else if (cart_load) begin
				if (cart_wr) begin
					// Each new word flips the request and stalls the host
					host_wait  <= 1'b1;
					mem_wr_req <= ~mem_wr_req;
				end else if (host_wait && (mem_wr_req == mem_wr_ack)) begin
					host_wait <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== src/cheat_loader.sv ====
// Cheat code assembler
`timescale 1ns/1ps
`include "md_loader_settings.svh"

module cheat_loader (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       code_wr,
	input  logic [`MD_ADDR_W-1:0]      addr,
	input  logic [`MD_DATA_W-1:0]      data,
	output md_loader_pkg::cheat_code_t cheat_code,
	output logic                       cheat_valid,
	output logic                       cheat_clear
);

	// Lower word of each pair is the low half
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (addr[3:0])
				`MD_CHEAT_FLAGS_LO: cheat_code.flags[15:0]    <= data;
				`MD_CHEAT_FLAGS_HI: cheat_code.flags[31:16]   <= data;
				`MD_CHEAT_ADDR_LO:  cheat_code.addr[15:0]     <= data;
				`MD_CHEAT_ADDR_HI:  cheat_code.addr[31:16]    <= data;
				`MD_CHEAT_CMP_LO:   cheat_code.compare[15:0]  <= data;
				`MD_CHEAT_CMP_HI:   cheat_code.compare[31:16] <= data;
				`MD_CHEAT_REPL_LO:  cheat_code.replace[15:0]  <= data;
				`MD_CHEAT_REPL_HI:  cheat_code.replace[31:16] <= data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Last word of a slot completes the code
			cheat_valid <= code_wr && (addr[3:0] == `MD_CHEAT_REPL_HI);
			// First word of the download wipes the old list
			cheat_clear <= code_wr && (addr == '0);
		end
	end

endmodule

// ==== src/md_loader_pkg.sv ====
// Cartridge loader types
package md_loader_pkg;

	// Console region codes as used by the host status word
	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	typedef enum logic [1:0] {
		FILE_EXT = 2'd0,
		HEADER   = 2'd1,
		DISABLED = 2'd2
	} region_mode_t;

	// Search order when resolving from the header letters
	typedef enum logic [1:0] {
		US_EU_JP = 2'd0,
		EU_US_JP = 2'd1,
		US_JP_EU = 2'd2,
		JP_US_EU = 2'd3
	} region_prio_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic fifo;
		logic noram;
		logic pier;
		logic ttn2;
		logic svp;
		logic fmbusy;
	} quirk_t;

	// Fields are big endian as delivered by the code generator
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

// ==== src/md_loader_top.sv ====
// Cartridge loader top level
`timescale 1ns/1ps
`include "md_loader_settings.svh"

module md_loader_top (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  logic                         download,
	input  logic [7:0]                   index,
	input  logic                         wr,
	input  logic [`MD_ADDR_W-1:0]        addr,
	input  logic [`MD_DATA_W-1:0]        data,
	input  logic                         mem_wr_ack,
	input  md_loader_pkg::region_mode_t  region_mode,
	input  md_loader_pkg::region_prio_t  region_prio,
	output logic                         host_wait,
	output logic [`MD_ADDR_W-1:0]        mem_addr,
	output logic [`MD_DATA_W-1:0]        mem_din,
	output logic                         mem_wr_req,
	output logic [`MD_ADDR_W-1:0]        rom_size,
	output md_loader_pkg::region_t       region_req,
	output logic                         region_set,
	output md_loader_pkg::quirk_t        quirks,
	output md_loader_pkg::cheat_code_t   cheat_code,
	output logic                         cheat_valid,
	output logic                         cheat_clear
);

	logic code_index;
	logic cart_load;
	logic code_load;
	logic cart_wr;
	logic code_wr;

	////////////////////////////////////////////////////////////
	// Download split by index
	////////////////////////////////////////////////////////////
	assign code_index = (index == `MD_CODE_INDEX);
	assign cart_load  = download & ~code_index;
	assign code_load  = download & code_index;
	assign cart_wr    = wr & cart_load;
	assign code_wr    = wr & code_load;

	////////////////////////////////////////////////////////////
	// Peers on the shared download bus
	////////////////////////////////////////////////////////////
	cart_writer i_cart_writer (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cart_load  (cart_load),
		.cart_wr    (cart_wr),
		.addr       (addr),
		.data       (data),
		.mem_wr_ack (mem_wr_ack),
		.host_wait  (host_wait),
		.mem_addr   (mem_addr),
		.mem_din    (mem_din),
		.mem_wr_req (mem_wr_req),
		.rom_size   (rom_size)
	);

	region_detect i_region_detect (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.cart_load   (cart_load),
		.cart_wr     (cart_wr),
		.addr        (addr),
		.data        (data),
		.index       (index),
		.region_mode (region_mode),
		.region_prio (region_prio),
		.region_req  (region_req),
		.region_set  (region_set)
	);

	quirk_detect i_quirk_detect (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.cart_load (cart_load),
		.cart_wr   (cart_wr),
		.addr      (addr),
		.data      (data),
		.quirks    (quirks)
	);

	cheat_loader i_cheat_loader (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.code_wr     (code_wr),
		.addr        (addr),
		.data        (data),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

endmodule

// ==== src/quirk_detect.sv ====
// Product serial quirk detection
`timescale 1ns/1ps
`include "md_loader_settings.svh"

module quirk_detect (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  cart_load,
	input  logic                  cart_wr,
	input  logic [`MD_ADDR_W-1:0] addr,
	input  logic [`MD_DATA_W-1:0] data,
	output md_loader_pkg::quirk_t quirks
);

	logic [63:0] serial;
	logic        load_d;

	// Known serials and the quirk each one needs
	function automatic md_loader_pkg::quirk_t lookup(input logic [63:0] id);
		md_loader_pkg::quirk_t q;
		q = '0;
		case (id)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ",
			"T-81476 ":
				q.sram = 1'b1;
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ",
			"G-5538  ", "00004076", "T-12046 ", "T-12053 ",
			"G-4524  ":
				q.eeprom = 1'b1;
			"T-113016":
				q.noram = 1'b1;
			"T-89016 ":
				q.fifo = 1'b1;
			"T-574023", "T-574013":
				q.pier = 1'b1;
			"TITAN002":
				q.ttn2 = 1'b1;
			"MK-1229 ", "G-7001  ":
				q.svp = 1'b1;
			"T-35036 ", "T-25073 ", "MK-1137-":
				q.fmbusy = 1'b1;
			default: ;
		endcase
		return q;
	endfunction

	// Serial bytes 0x183 to 0x18A with odd bytes in the high half
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			case (addr)
				`MD_SERIAL_FIRST:          serial[63:56] <= data[15:8];
				`MD_SERIAL_FIRST + 25'd2:  serial[55:40] <= {data[7:0], data[15:8]};
				`MD_SERIAL_FIRST + 25'd4:  serial[39:24] <= {data[7:0], data[15:8]};
				`MD_SERIAL_FIRST + 25'd6:  serial[23:8]  <= {data[7:0], data[15:8]};
				`MD_SERIAL_FIRST + 25'd8:  serial[7:0]   <= data[7:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			load_d <= 1'b0;
			quirks <= '0;
		end else begin
			load_d <= cart_load;
			if (!load_d && cart_load)
				quirks <= '0;
			else if (cart_wr && addr == `MD_SERIAL_DONE)
				quirks <= quirks | lookup(serial);
		end
	end

endmodule

// ==== src/region_detect.sv ====
// Header region detection
`timescale 1ns/1ps
`include "md_loader_settings.svh"

module region_detect (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  logic                         cart_load,
	input  logic                         cart_wr,
	input  logic [`MD_ADDR_W-1:0]        addr,
	input  logic [`MD_DATA_W-1:0]        data,
	input  logic [7:0]                   index,
	input  md_loader_pkg::region_mode_t  region_mode,
	input  md_loader_pkg::region_prio_t  region_prio,
	output md_loader_pkg::region_t       region_req,
	output logic                         region_set
);

	// One flag per region code with bit 0 J, bit 1 U and bit 2 E
	logic [2:0] hdr_flags;
	logic       hdr_ready;
	logic       hdr_ready_d;
	logic       load_d;

	// Classify one header letter
	function automatic logic [2:0] classify(input logic [7:0] ch);
		logic [2:0] f;
		f = 3'b000;
		if (ch == "J")
			f[0] = 1'b1;
		else if (ch == "U")
			f[1] = 1'b1;
		else if (ch >= "0" && ch <= "Z")
			f[2] = 1'b1;
		return f;
	endfunction

	// First flagged region in priority order or the first of the order
	function automatic md_loader_pkg::region_t pick(
		input md_loader_pkg::region_prio_t prio,
		input logic [2:0]                  flags
	);
		md_loader_pkg::region_t order [3];
		md_loader_pkg::region_t r;
		int                     i;
		case (prio)
			md_loader_pkg::US_EU_JP: order = '{md_loader_pkg::US, md_loader_pkg::EU, md_loader_pkg::JP};
			md_loader_pkg::EU_US_JP: order = '{md_loader_pkg::EU, md_loader_pkg::US, md_loader_pkg::JP};
			md_loader_pkg::US_JP_EU: order = '{md_loader_pkg::US, md_loader_pkg::JP, md_loader_pkg::EU};
			default:                 order = '{md_loader_pkg::JP, md_loader_pkg::US, md_loader_pkg::EU};
		endcase
		r = order[0];
		// Walk backwards so the earliest match wins
		for (i = 2; i >= 0; i--) begin
			if (flags[order[i]])
				r = order[i];
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Header letters
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			load_d    <= 1'b0;
			hdr_flags <= 3'b000;
			hdr_ready <= 1'b0;
		end else begin
			load_d <= cart_load;
			if (!load_d && cart_load)
				hdr_flags <= 3'b000;
			if (load_d && !cart_load)
				hdr_ready <= 1'b0;

			if (cart_wr) begin
				if (addr == `MD_HDR_REGION_A)
					hdr_flags <= hdr_flags | classify(data[7:0]) | classify(data[15:8]);
				else if (addr == `MD_HDR_REGION_B)
					hdr_flags <= hdr_flags | classify(data[7:0]);
				if (addr == `MD_HDR_END)
					hdr_ready <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Region request
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hdr_ready_d <= 1'b0;
			region_req  <= md_loader_pkg::JP;
			region_set  <= 1'b0;
		end else begin
			hdr_ready_d <= hdr_ready;
			if (!hdr_ready_d && hdr_ready) begin
				case (region_mode)
					md_loader_pkg::HEADER: begin
						region_set <= 1'b1;
						region_req <= pick(region_prio, hdr_flags);
					end
					md_loader_pkg::FILE_EXT: begin
						// Extension code sits in the top index bits
						region_set <= |index;
						region_req <= md_loader_pkg::region_t'(index[7:6]);
					end
					default: ;  // keep previous request
				endcase
			end
			if (hdr_ready_d && !hdr_ready)
				region_set <= 1'b0;
		end
	end

endmodule

// ==== verif/md_loader_cases.txt ====
# kind index mode prio hdr_a hdr_b serial(hex ascii) words flags addr compare replace quirks
# mode 0 file ext, 1 header, 2 disabled; prio 0 US_EU_JP, 1 EU_US_JP, 2 US_JP_EU, 3 JP_US_EU
cart 01 1 0 554A 2045 542D303831323736 260 0 0 0 0 80
cart 02 1 1 2045 2020 472D343036302020 261 0 0 0 0 40
cart 03 1 3 2020 2020 542D383930313620 258 0 0 0 0 20
cart 04 1 2 204A 2020 542D313133303136 257 0 0 0 0 10
cart 05 1 1 2055 2020 542D353734303233 270 0 0 0 0 08
cart 80 0 0 554A 2045 544954414E303032 263 0 0 0 0 04
cart 40 0 0 2020 2020 4D4B2D3132323920 259 0 0 0 0 02
cart 06 2 0 4A4A 2020 542D333530333620 262 0 0 0 0 01
cart 00 0 0 2045 2020 414243442D313233 257 0 0 0 0 00
cheat ff 0 0 0 0 0 0 00000001 00FF1234 0000ABCD 00001234 00
cheat ff 0 0 0 0 0 0 DEADBEEF 12345678 9ABCDEF0 0F0F0F0F 00
cart 41 1 0 2020 2045 4D4B2D3132323920 264 0 0 0 0 02

// ==== verif/md_loader_chk.sv ====
// Cartridge loader assertions
`timescale 1ns/1ps

module md_loader_chk (
	input logic clk_sys,
	input logic rst_n,
	input logic cart_load,
	input logic cart_wr,
	input logic host_wait,
	input logic mem_wr_req,
	input logic cheat_valid
);

	// Memory handshake idle right after reset release
	a_reset_idle: assert property (@(posedge clk_sys)
		$rose(rst_n) |-> (!host_wait && !mem_wr_req))
		else $error("host_wait or mem_wr_req high after reset");

	// Request moves only after a cart write or at the start of a download
	a_req_toggle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$changed(mem_wr_req) |-> ($past(cart_wr) || ($past(cart_load) && !$past(cart_load, 2))))
		else $error("mem_wr_req changed without a cart write");

	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cheat_valid |=> !cheat_valid)
		else $error("cheat_valid held for two cycles");

endmodule

bind md_loader_top md_loader_chk i_chk (
	.clk_sys     (clk_sys),
	.rst_n       (rst_n),
	.cart_load   (cart_load),
	.cart_wr     (cart_wr),
	.host_wait   (host_wait),
	.mem_wr_req  (mem_wr_req),
	.cheat_valid (cheat_valid)
);

// ==== verif/md_loader_tb.sv ====
// Cartridge loader testbench
`timescale 1ns/1ps
`include "md_loader_settings.svh"

module md_loader_tb;

	localparam int MAX_CASES = 32;

	logic                        clk_sys;
	logic                        rst_n;
	logic                        download;
	logic [7:0]                  index;
	logic                        wr;
	logic [`MD_ADDR_W-1:0]       addr;
	logic [`MD_DATA_W-1:0]       data;
	logic                        mem_wr_ack;
	md_loader_pkg::region_mode_t region_mode;
	md_loader_pkg::region_prio_t region_prio;
	logic                        host_wait;
	logic [`MD_ADDR_W-1:0]       mem_addr;
	logic [`MD_DATA_W-1:0]       mem_din;
	logic                        mem_wr_req;
	logic [`MD_ADDR_W-1:0]       rom_size;
	md_loader_pkg::region_t      region_req;
	logic                        region_set;
	md_loader_pkg::quirk_t       quirks;
	md_loader_pkg::cheat_code_t  cheat_code;
	logic                        cheat_valid;
	logic                        cheat_clear;

	// Case table
	logic        c_cheat  [MAX_CASES];
	logic [7:0]  c_index  [MAX_CASES];
	logic [1:0]  c_mode   [MAX_CASES];
	logic [1:0]  c_prio   [MAX_CASES];
	logic [15:0] c_hdr_a  [MAX_CASES];
	logic [15:0] c_hdr_b  [MAX_CASES];
	logic [63:0] c_serial [MAX_CASES];
	int          c_words  [MAX_CASES];
	logic [31:0] c_field  [MAX_CASES][4];
	logic [7:0]  c_quirk  [MAX_CASES];
	int          n_cases;
	int          total_words;
	logic        cases_loaded;
	integer      seed;
	logic        req_exp;
	logic [1:0]  prev_region;

	md_loader_top i_dut (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.download    (download),
		.index       (index),
		.wr          (wr),
		.addr        (addr),
		.data        (data),
		.mem_wr_ack  (mem_wr_ack),
		.region_mode (region_mode),
		.region_prio (region_prio),
		.host_wait   (host_wait),
		.mem_addr    (mem_addr),
		.mem_din     (mem_din),
		.mem_wr_req  (mem_wr_req),
		.rom_size    (rom_size),
		.region_req  (region_req),
		.region_set  (region_set),
		.quirks      (quirks),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
		if (got !== exp) begin
			$display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
			$display("TEST FAIL");
			$fatal(1, "mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Expected values
	////////////////////////////////////////////////////////////

	// Image byte b inside the serial field or the fallback byte
	function automatic logic [7:0] serial_byte(input logic [63:0] s, input int b,
			input logic [7:0] fallback);
		int k;
		k = b - 'h183;
		if (k < 0 || k > 7)
			return fallback;
		return s[63 - 8*k -: 8];
	endfunction

	function automatic logic [15:0] image_word(input int c, input int a, input logic [15:0] fill);
		logic [7:0] lo;
		logic [7:0] hi;
		if (a == 'h1F0)
			return c_hdr_a[c];
		if (a == 'h1F2)
			return c_hdr_b[c];
		lo = serial_byte(c_serial[c], a, fill[7:0]);
		hi = serial_byte(c_serial[c], a + 1, fill[15:8]);
		return {hi, lo};
	endfunction

	function automatic logic [2:0] letter_flags(input logic [7:0] ch);
		// Bit 0 Japan, bit 1 USA, bit 2 Europe
		if (ch == 8'h4A)
			return 3'b001;
		if (ch == 8'h55)
			return 3'b010;
		if (ch >= 8'h30 && ch <= 8'h5A)
			return 3'b100;
		return 3'b000;
	endfunction

	function automatic logic [1:0] header_region(input int c);
		logic [2:0] fl;
		logic [1:0] order [3];
		int         i;
		fl = letter_flags(c_hdr_a[c][7:0]) | letter_flags(c_hdr_a[c][15:8])
			| letter_flags(c_hdr_b[c][7:0]);
		case (c_prio[c])
			2'd0: order = '{2'd1, 2'd2, 2'd0};
			2'd1: order = '{2'd2, 2'd1, 2'd0};
			2'd2: order = '{2'd1, 2'd0, 2'd2};
			default: order = '{2'd0, 2'd1, 2'd2};
		endcase
		for (i = 0; i < 3; i++) begin
			if (fl[order[i]])
				return order[i];
		end
		return order[0];
	endfunction

	////////////////////////////////////////////////////////////
	// Host and memory side
	////////////////////////////////////////////////////////////

	// One cart word acknowledged by the memory after a random delay
	task automatic cart_word(input int a, input logic [15:0] d);
		logic [31:0] r;
		int          delay;
		@(negedge clk_sys);
		addr = `MD_ADDR_W'(a);
		data = d;
		wr   = 1'b1;
		@(negedge clk_sys);
		wr      = 1'b0;
		req_exp = ~req_exp;
		check(128'(host_wait), 128'(1'b1), "host_wait after write");
		check(128'(mem_wr_req), 128'(req_exp), "mem_wr_req level");
		check(128'(mem_addr), 128'(a), "mem_addr");
		check(128'(mem_din), 128'({d[7:0], d[15:8]}), "mem_din");
		r     = $random(seed);
		delay = int'(r[2:0]);
		if (delay > 5)
			delay = delay - 6;
		repeat (delay) @(negedge clk_sys);
		mem_wr_ack = mem_wr_req;
		while (host_wait)
			@(negedge clk_sys);
	endtask

	task automatic run_cart(input int c);
		logic [31:0] r;
		logic [15:0] w;
		int          i;
		@(negedge clk_sys);
		index       = c_index[c];
		region_mode = md_loader_pkg::region_mode_t'(c_mode[c]);
		region_prio = md_loader_pkg::region_prio_t'(c_prio[c]);
		mem_wr_ack  = 1'b0;
		req_exp     = 1'b0;
		download    = 1'b1;
		@(negedge clk_sys);
		for (i = 0; i < c_words[c]; i++) begin
			r = $random(seed);
			w = image_word(c, 2*i, r[15:0]);
			cart_word(2*i, w);
		end
		check(128'(quirks), 128'(c_quirk[c]), "quirks");
		if (c_mode[c] == 2'd1) begin
			prev_region = header_region(c);
			check(128'(region_set), 128'(1'b1), "region_set in header mode");
		end else if (c_mode[c] == 2'd0) begin
			prev_region = c_index[c][7:6];
			check(128'(region_set), 128'(|c_index[c]), "region_set in file mode");
		end else begin
			check(128'(region_set), 128'(1'b0), "region_set when disabled");
		end
		check(128'(region_req), 128'(prev_region), "region_req");
		download = 1'b0;
		repeat (2) @(negedge clk_sys);
		check(128'(rom_size), 128'(2*(c_words[c] - 1)), "rom_size");
		check(128'(mem_addr), 128'(2*(c_words[c] - 1)), "mem_addr after download");
		check(128'(host_wait), 128'(1'b0), "host_wait after download");
		check(128'(region_set), 128'(1'b0), "region_set after download");
	endtask

	task automatic run_cheat(input int c);
		logic [15:0] w;
		int          off;
		@(negedge clk_sys);
		index    = `MD_CODE_INDEX;
		download = 1'b1;
		@(negedge clk_sys);
		for (off = 0; off < 16; off += 2) begin
			w = off[1] ? c_field[c][off/4][31:16] : c_field[c][off/4][15:0];
			addr = `MD_ADDR_W'(off);
			data = w;
			wr   = 1'b1;
			@(negedge clk_sys);
			wr = 1'b0;
			check(128'(cheat_clear), 128'(off == 0), "cheat_clear pulse");
			check(128'(cheat_valid), 128'(off == 14), "cheat_valid pulse");
			@(negedge clk_sys);
			check(128'({cheat_valid, cheat_clear}), 128'(2'b00), "pulse width");
		end
		check(128'(cheat_code), {c_field[c][0], c_field[c][1], c_field[c][2], c_field[c][3]},
			"cheat_code");
		download = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic load_cases();
		int          fd;
		int          n;
		string       line;
		string       kind;
		logic [7:0]  t_idx;
		logic [1:0]  t_mode;
		logic [1:0]  t_prio;
		logic [15:0] t_a;
		logic [15:0] t_b;
		logic [63:0] t_ser;
		int          t_len;
		logic [31:0] t_f [4];
		logic [7:0]  t_q;
		fd = $fopen("verif/md_loader_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file verif/md_loader_cases.txt");
			$display("TEST FAIL");
			$fatal(1, "no cases");
		end
		while (!$feof(fd) && n_cases < MAX_CASES) begin
			n = $fgets(line, fd);
			if (n == 0)
				continue;
			if (line.len() < 4 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %h %h %h %h %h %h %d %h %h %h %h %h", kind, t_idx, t_mode,
				t_prio, t_a, t_b, t_ser, t_len, t_f[0], t_f[1], t_f[2], t_f[3], t_q);
			if (n != 13)
				continue;
			c_cheat[n_cases]  = (kind == "cheat");
			c_index[n_cases]  = t_idx;
			c_mode[n_cases]   = t_mode;
			c_prio[n_cases]   = t_prio;
			c_hdr_a[n_cases]  = t_a;
			c_hdr_b[n_cases]  = t_b;
			c_serial[n_cases] = t_ser;
			c_words[n_cases]  = t_len;
			c_field[n_cases]  = t_f;
			c_quirk[n_cases]  = t_q;
			total_words += (kind == "cheat") ? 16 : t_len;
			n_cases++;
		end
		$fclose(fd);
	endtask

	// Watchdog sized from the total download length
	initial begin
		wait (cases_loaded);
		repeat (total_words * 10 + 200) @(posedge clk_sys);
		$display("Timeout: the downloads did not complete in time");
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		int c;
		rst_n        = 1'b0;
		download     = 1'b0;
		index        = 8'h00;
		wr           = 1'b0;
		addr         = '0;
		data         = '0;
		mem_wr_ack   = 1'b0;
		region_mode  = md_loader_pkg::HEADER;
		region_prio  = md_loader_pkg::US_EU_JP;
		seed         = 32'h9846_0b1d;
		req_exp      = 1'b0;
		prev_region  = 2'd0;
		n_cases      = 0;
		total_words  = 0;
		cases_loaded = 1'b0;
		load_cases();
		cases_loaded = 1'b1;
		if (n_cases == 0) begin
			$display("The case file holds no usable case");
			$display("TEST FAIL");
			$fatal(1, "no cases");
		end
		repeat (2) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		check(128'({host_wait, mem_wr_req, region_set, cheat_valid, cheat_clear}), 128'(0),
			"outputs after reset");
		for (c = 0; c < n_cases; c++) begin
			if (c_cheat[c])
				run_cheat(c);
			else
				run_cart(c);
		end
		repeat (4) @(negedge clk_sys);
		$display("TEST PASS");
		$finish;
	end

endmodule
